/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ooo_core
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+test
source/ooo_pkg.sv
source/dispatch_stage.sv
source/rob.sv
source/alu_unit.sv
source/mul_unit.sv
source/commit_stage.sv
source/ooo_core.sv
test/tb_ooo_core.sv

/* source/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     alu_issue,
    input  op_t      iss_op,
    input  word_t    iss_a,
    input  word_t    iss_b,
    input  rob_idx_t iss_idx,
    input  logic     iss_epoch,

    output logic     alu_wb_valid,
    output rob_idx_t alu_wb_idx,
    output logic     alu_wb_epoch,
    output word_t    alu_wb_data,
    output logic     alu_wb_taken
);

    word_t result;

    always_comb begin
        case (iss_op)
            op_add:  result = iss_a + iss_b;
            op_sub:  result = iss_a - iss_b;
            op_xor:  result = iss_a ^ iss_b;
            default: result = '0;   // beq reports zero data
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_idx   <= iss_idx;
        alu_wb_epoch <= iss_epoch;
        alu_wb_data  <= result;
        alu_wb_taken <= (iss_op == op_beq) && (iss_a == iss_b);
    end

endmodule

/* source/commit_stage.sv */
`timescale 1ns/1ps

module commit_stage
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      ret_valid,
    input  reg_addr_t ret_rd,
    input  word_t     ret_data,
    input  logic      ret_flush,

    input  reg_addr_t dbg_addr,

    output logic      commit_valid,
    output reg_addr_t commit_rd,
    output word_t     commit_data,
    output order_t    commit_order,
    output logic      flush,
    output word_t     dbg_data
);

    word_t  regs [NUM_REGS];    // architectural state
    order_t order_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
            order_cnt    <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            commit_valid <= ret_valid;
            flush        <= ret_valid && ret_flush;
            if (ret_valid) begin
                order_cnt <= order_cnt + 1'b1;
                if (ret_rd != '0) begin   // x0 stays zero, branches arrive as rd 0
                    regs[ret_rd] <= ret_data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        commit_rd    <= ret_rd;
        commit_data  <= ret_data;
        commit_order <= order_cnt;
    end

    assign dbg_data = regs[dbg_addr];

endmodule

/* source/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      in_valid,
    input  op_t       in_op,
    input  reg_addr_t in_rd,
    input  word_t     in_a,
    input  word_t     in_b,

    input  rob_idx_t  tail_idx,
    input  logic      cur_epoch,

    output logic      alloc_valid,
    output op_t       alloc_op,
    output reg_addr_t alloc_rd,
    output logic      alloc_epoch,

    output logic      alu_issue,
    output logic      mul_issue,
    output word_t     iss_a,
    output word_t     iss_b,
    output rob_idx_t  iss_idx,
    output logic      iss_epoch,
    output op_t       iss_op
);

    logic      hold_valid;
    op_t       hold_op;
    reg_addr_t hold_rd;
    word_t     hold_a;
    word_t     hold_b;
    logic      hold_epoch;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= in_valid; // credits guarantee a free slot
        end
    end

    always_ff @(posedge clk) begin
        hold_op    <= in_op;
        hold_rd    <= in_rd;
        hold_a     <= in_a;
        hold_b     <= in_b;
        hold_epoch <= cur_epoch;    // stale if a flush happens at this edge
    end

    assign alloc_valid = hold_valid;
    assign alloc_op    = hold_op;
    assign alloc_rd    = hold_rd;
    assign alloc_epoch = hold_epoch;

    // exactly one unit takes each instruction
    assign mul_issue = hold_valid && (hold_op == op_mul);
    assign alu_issue = hold_valid && (hold_op != op_mul);

    assign iss_op    = hold_op;
    assign iss_a     = hold_a;
    assign iss_b     = hold_b;
    assign iss_idx   = tail_idx;    // slot allocated at the same edge
    assign iss_epoch = hold_epoch;

endmodule

/* source/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     mul_issue,
    input  word_t    iss_a,
    input  word_t    iss_b,
    input  rob_idx_t iss_idx,
    input  logic     iss_epoch,

    output logic     mul_wb_valid,
    output rob_idx_t mul_wb_idx,
    output logic     mul_wb_epoch,
    output word_t    mul_wb_data
);

    logic [MUL_STAGES-1:0] st_valid;
    logic [MUL_STAGES-1:0] st_epoch;
    rob_idx_t              st_idx [MUL_STAGES];
    word_t                 st_acc [MUL_STAGES];
    word_t                 st_a   [MUL_STAGES-1];   // last stage only adds
    word_t                 st_b   [MUL_STAGES-1];

    // low word of a times one byte of b shifted into place
    function automatic word_t partial(input word_t a, input word_t b, input int s);
        logic [7:0] b_byte;
        b_byte = b[8*s +: 8];
        return (a * {24'd0, b_byte}) << (8 * s);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= '0;
        end else begin
            st_valid <= {st_valid[MUL_STAGES-2:0], mul_issue};
        end
    end

    always_ff @(posedge clk) begin
        st_acc[0]   <= partial(iss_a, iss_b, 0);
        st_a[0]     <= iss_a;
        st_b[0]     <= iss_b;
        st_idx[0]   <= iss_idx;
        st_epoch[0] <= iss_epoch;
        for (int s = 1; s < MUL_STAGES; s++) begin
            st_acc[s]   <= st_acc[s-1] + partial(st_a[s-1], st_b[s-1], s);
            st_idx[s]   <= st_idx[s-1];   // tag rides with the data
            st_epoch[s] <= st_epoch[s-1];
        end
        for (int s = 1; s < MUL_STAGES-1; s++) begin
            st_a[s] <= st_a[s-1];
            st_b[s] <= st_b[s-1];
        end
    end

    assign mul_wb_valid = st_valid[MUL_STAGES-1];
    assign mul_wb_idx   = st_idx[MUL_STAGES-1];
    assign mul_wb_epoch = st_epoch[MUL_STAGES-1];
    assign mul_wb_data  = st_acc[MUL_STAGES-1];

endmodule

/* source/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      in_valid,
    input  op_t       in_op,
    input  reg_addr_t in_rd,
    input  word_t     in_a,
    input  word_t     in_b,
    input  reg_addr_t dbg_addr,

    output rob_cnt_t  credit_cnt,
    output logic      commit_valid,
    output reg_addr_t commit_rd,
    output word_t     commit_data,
    output order_t    commit_order,
    output logic      flush,
    output word_t     dbg_data
);

    logic      alloc_valid;
    op_t       alloc_op;
    reg_addr_t alloc_rd;
    logic      alloc_epoch;
    rob_idx_t  tail_idx;
    logic      cur_epoch;

    logic      alu_issue;
    logic      mul_issue;
    op_t       iss_op;
    word_t     iss_a;
    word_t     iss_b;
    rob_idx_t  iss_idx;
    logic      iss_epoch;

    logic      alu_wb_valid;
    rob_idx_t  alu_wb_idx;
    logic      alu_wb_epoch;
    word_t     alu_wb_data;
    logic      alu_wb_taken;

    logic      mul_wb_valid;
    rob_idx_t  mul_wb_idx;
    logic      mul_wb_epoch;
    word_t     mul_wb_data;

    logic      ret_valid;
    reg_addr_t ret_rd;
    word_t     ret_data;
    logic      ret_flush;

    dispatch_stage dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_rd       (in_rd),
        .in_a        (in_a),
        .in_b        (in_b),
        .tail_idx    (tail_idx),
        .cur_epoch   (cur_epoch),
        .alloc_valid (alloc_valid),
        .alloc_op    (alloc_op),
        .alloc_rd    (alloc_rd),
        .alloc_epoch (alloc_epoch),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue),
        .iss_a       (iss_a),
        .iss_b       (iss_b),
        .iss_idx     (iss_idx),
        .iss_epoch   (iss_epoch),
        .iss_op      (iss_op)
    );

    rob rob_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_op     (alloc_op),
        .alloc_rd     (alloc_rd),
        .alloc_epoch  (alloc_epoch),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_idx   (alu_wb_idx),
        .alu_wb_epoch (alu_wb_epoch),
        .alu_wb_data  (alu_wb_data),
        .alu_wb_taken (alu_wb_taken),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb_idx   (mul_wb_idx),
        .mul_wb_epoch (mul_wb_epoch),
        .mul_wb_data  (mul_wb_data),
        .tail_idx     (tail_idx),
        .cur_epoch    (cur_epoch),
        .ret_valid    (ret_valid),
        .ret_rd       (ret_rd),
        .ret_data     (ret_data),
        .ret_flush    (ret_flush),
        .credit_cnt   (credit_cnt)
    );

    alu_unit alu_i (
        .clk          (clk),
        .rst          (rst),
        .alu_issue    (alu_issue),
        .iss_op       (iss_op),
        .iss_a        (iss_a),
        .iss_b        (iss_b),
        .iss_idx      (iss_idx),
        .iss_epoch    (iss_epoch),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_idx   (alu_wb_idx),
        .alu_wb_epoch (alu_wb_epoch),
        .alu_wb_data  (alu_wb_data),
        .alu_wb_taken (alu_wb_taken)
    );

    mul_unit mul_i (
        .clk          (clk),
        .rst          (rst),
        .mul_issue    (mul_issue),
        .iss_a        (iss_a),
        .iss_b        (iss_b),
        .iss_idx      (iss_idx),
        .iss_epoch    (iss_epoch),
        .mul_wb_valid (mul_wb_valid),
        .mul_wb_idx   (mul_wb_idx),
        .mul_wb_epoch (mul_wb_epoch),
        .mul_wb_data  (mul_wb_data)
    );

    commit_stage commit_i (
        .clk          (clk),
        .rst          (rst),
        .ret_valid    (ret_valid),
        .ret_rd       (ret_rd),
        .ret_data     (ret_data),
        .ret_flush    (ret_flush),
        .dbg_addr     (dbg_addr),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_order (commit_order),
        .flush        (flush),
        .dbg_data     (dbg_data)
    );

endmodule

/* source/ooo_pkg.sv */
package ooo_pkg;

    localparam int ROB_DEPTH  = 16;
    localparam int ROB_IDX_W  = 4;
    localparam int MUL_STAGES = 4;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int WORD_W     = 32;
    localparam int ORDER_W    = 64;

    // reorder buffer slot number
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // 0 .. ROB_DEPTH inclusive, needs one more bit than an index
    typedef logic [ROB_IDX_W:0] rob_cnt_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // retirement sequence number
    typedef logic [ORDER_W-1:0] order_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_xor = 3'd2,
        op_mul = 3'd3,
        op_beq = 3'd4   // compare only, no register write
    } op_t;

endpackage

/* source/rob.sv */
`timescale 1ns/1ps

module rob
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      alloc_valid,
    input  op_t       alloc_op,
    input  reg_addr_t alloc_rd,
    input  logic      alloc_epoch,

    input  logic      alu_wb_valid,
    input  rob_idx_t  alu_wb_idx,
    input  logic      alu_wb_epoch,
    input  word_t     alu_wb_data,
    input  logic      alu_wb_taken,

    input  logic      mul_wb_valid,
    input  rob_idx_t  mul_wb_idx,
    input  logic      mul_wb_epoch,
    input  word_t     mul_wb_data,

    output rob_idx_t  tail_idx,
    output logic      cur_epoch,

    output logic      ret_valid,
    output reg_addr_t ret_rd,
    output word_t     ret_data,
    output logic      ret_flush,

    output rob_cnt_t  credit_cnt
);

    logic [ROB_IDX_W:0] head;   // msb is the wrap bit
    logic [ROB_IDX_W:0] tail;
    rob_idx_t           head_idx;
    rob_cnt_t           used;
    rob_cnt_t           freed;

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ROB_DEPTH-1:0] ent_branch;
    logic [ROB_DEPTH-1:0] ent_taken;
    reg_addr_t            ent_rd   [ROB_DEPTH];
    word_t                ent_data [ROB_DEPTH];

    logic retire;
    logic do_flush;
    logic alloc_ok;
    logic alloc_drop;
    logic alu_hit;
    logic mul_hit;

    assign head_idx = head[ROB_IDX_W-1:0];
    assign tail_idx = tail[ROB_IDX_W-1:0];
    assign used     = tail - head;

    assign retire   = ent_valid[head_idx] && ent_done[head_idx];
    assign do_flush = retire && ent_branch[head_idx] && ent_taken[head_idx];

    // anything arriving on the flush edge is younger than the branch
    assign alloc_ok   = alloc_valid && (alloc_epoch == cur_epoch) && !do_flush;
    assign alloc_drop = alloc_valid && !alloc_ok;

    // results from squashed work carry the old epoch
    assign alu_hit = alu_wb_valid && (alu_wb_epoch == cur_epoch) && ent_valid[alu_wb_idx];
    assign mul_hit = mul_wb_valid && (mul_wb_epoch == cur_epoch) && ent_valid[mul_wb_idx];

    always_comb begin
        freed = '0;
        if (do_flush) begin
            freed = used;   // branch plus everything behind it
        end else if (retire) begin
            freed = rob_cnt_t'(1);
        end
        if (alloc_drop) begin
            freed = freed + rob_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            ent_valid  <= '0;
            ent_done   <= '0;
            cur_epoch  <= 1'b0;
            ret_valid  <= 1'b0;
            ret_flush  <= 1'b0;
            credit_cnt <= '0;
        end else begin
            ret_valid  <= retire;
            ret_flush  <= do_flush;
            credit_cnt <= freed;

            if (alu_hit) begin
                ent_done[alu_wb_idx] <= 1'b1;
            end
            if (mul_hit) begin
                ent_done[mul_wb_idx] <= 1'b1;
            end

            if (do_flush) begin
                ent_valid <= '0;
                head      <= tail;
                cur_epoch <= ~cur_epoch;
            end else begin
                if (retire) begin
                    ent_valid[head_idx] <= 1'b0;
                    head                <= head + 1'b1;
                end
                if (alloc_ok) begin
                    ent_valid[tail_idx] <= 1'b1;
                    ent_done[tail_idx]  <= 1'b0;
                    tail                <= tail + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            ent_rd[tail_idx]     <= alloc_rd;
            ent_branch[tail_idx] <= (alloc_op == op_beq);
        end
        if (alu_hit) begin
            ent_data[alu_wb_idx]  <= alu_wb_data;
            ent_taken[alu_wb_idx] <= alu_wb_taken;
        end
        if (mul_hit) begin
            ent_data[mul_wb_idx]  <= mul_wb_data;
            ent_taken[mul_wb_idx] <= 1'b0;
        end
        ret_rd   <= ent_branch[head_idx] ? '0 : ent_rd[head_idx]; // branches never write
        ret_data <= ent_data[head_idx];
    end

endmodule

/* test/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one instruction as the commit port should show it
typedef struct packed {
    reg_addr_t rd;      // 0 for a branch
    word_t     data;
    logic      taken;
    int        stamp;   // tb cycle in which the source drove it
} exp_entry_t;

exp_entry_t exp_q[$];
word_t      model_regs [NUM_REGS];

function automatic word_t ref_result(input op_t op, input word_t a, input word_t b);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_xor:  return a ^ b;
        op_mul:  return prod[31:0];   // low word only
        default: return '0;
    endcase
endfunction

// beq is taken on equal operands
function automatic logic ref_taken(input op_t op, input word_t a, input word_t b);
    return (op == op_beq) && (a == b);
endfunction

function automatic void push_expected(input op_t op, input reg_addr_t rd, input word_t a,
                                      input word_t b, input int stamp);
    exp_entry_t e;
    e.rd    = (op == op_beq) ? reg_addr_t'(0) : rd;
    e.data  = ref_result(op, a, b);
    e.taken = ref_taken(op, a, b);
    e.stamp = stamp;
    exp_q.push_back(e);
endfunction

function automatic void retire_expected(input exp_entry_t e);
    if (e.rd != '0) begin
        model_regs[e.rd] = e.data;   // x0 never changes
    end
endfunction

`endif

/* test/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int N_ALU     = 40;
    localparam int N_MIX     = 60;
    localparam int N_BURST   = 80;
    localparam int N_BRANCH  = 80;
    localparam int WDOG_CYC  = (N_ALU + N_MIX + N_BURST + N_BRANCH) * 12 + 200;

    logic      clk;
    logic      rst;
    logic      in_valid;
    op_t       in_op;
    reg_addr_t in_rd;
    word_t     in_a;
    word_t     in_b;
    reg_addr_t dbg_addr;
    rob_cnt_t  credit_cnt;
    logic      commit_valid;
    reg_addr_t commit_rd;
    word_t     commit_data;
    order_t    commit_order;
    logic      flush;
    word_t     dbg_data;

    int          credits;
    int          cyc = 0;
    int          errors = 0;
    int          commits = 0;
    int          squashed = 0;
    int          tests_failed = 0;
    longint      exp_order = 0;
    logic [31:0] lfsr = 32'h40da_e5fc;

    `include "tb_ref_model.svh"

    ooo_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_a         (in_a),
        .in_b         (in_b),
        .dbg_addr     (dbg_addr),
        .credit_cnt   (credit_cnt),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_order (commit_order),
        .flush        (flush),
        .dbg_data     (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // source side credit count with returned slots added at every edge
    always @(posedge clk) begin
        if (rst) begin
            credits <= ROB_DEPTH;
        end else begin
            credits <= credits + int'(credit_cnt) - (in_valid ? 1 : 0);
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic word_t next_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic op_t pick_op(input bit use_mul, input bit use_beq);
        logic [2:0] r;
        r = 3'(next_bits(3));
        case (r)
            3'd0, 3'd1: return op_add;
            3'd2:       return op_sub;
            3'd3:       return op_xor;
            3'd4, 3'd5: return use_mul ? op_mul : op_sub;
            default:    return use_beq ? op_beq : op_xor;
        endcase
    endfunction

    task automatic drive_stream(input int count, input bit use_mul, input bit use_beq,
                                input bit bursty);
        int        sent;
        int        burst_left;
        int        gap;
        op_t       op;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        sent       = 0;
        burst_left = 0;
        gap        = 0;
        while (sent < count) begin
            @(negedge clk);
            in_valid = 1'b0;
            assert (credits >= 0 && credits <= ROB_DEPTH) else begin
                errors++;
                $display("[ERROR] %0t credit count %0d out of range", $time, credits);
            end
            if (bursty && burst_left == 0) begin
                burst_left = 8 + int'(next_bits(4));   // may outrun the credits
                gap        = int'(next_bits(4));
            end
            if (gap > 0) begin
                gap--;
            end else if (credits > 0) begin
                op = pick_op(use_mul, use_beq);
                rd = reg_addr_t'(next_bits(5));
                a  = next_bits(32);
                b  = next_bits(32);
                if (op == op_beq && next_bits(1) == 32'd1) begin
                    b = a;   // taken
                end
                in_valid = 1'b1;
                in_op    = op;
                in_rd    = rd;
                in_a     = a;
                in_b     = b;
                push_expected(op, rd, a, b, cyc);
                sent++;
                if (bursty) begin
                    burst_left--;
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic check_commit();
        exp_entry_t e;
        int         limit;
        commits++;
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("commit seen at %0t with no instruction left to retire", $time);
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (commit_rd == e.rd) else begin
                errors++;
                $display("[ERROR] %0t commit rd %0d, expected %0d", $time, commit_rd, e.rd);
            end
            assert (commit_data == e.data) else begin
                errors++;
                $display("[ERROR] %0t commit data %h, expected %h", $time, commit_data, e.data);
            end
            assert (commit_order == order_t'(exp_order)) else begin
                errors++;
                $display("[ERROR] %0t commit order %0d, expected %0d", $time, commit_order,
                         exp_order);
            end
            assert (flush == e.taken) else begin
                errors++;
                $display("[ERROR] %0t flush %b, expected %b", $time, flush, e.taken);
            end
            retire_expected(e);
            exp_order++;
            if (e.taken) begin
                // anything driven up to the retiring edge still carries the old epoch
                limit = cyc - 2;
                while (exp_q.size() > 0 && exp_q[0].stamp <= limit) begin
                    void'(exp_q.pop_front());
                    squashed++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (commit_valid) begin
                check_commit();
            end else begin
                assert (flush == 1'b0) else begin
                    errors++;
                    $display("[ERROR] %0t flush raised without a commit", $time);
                end
            end
        end
    end

    task automatic drain_core();
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);   // last freed slots reach the counter
    endtask

    task automatic check_registers();
        for (int i = 0; i < NUM_REGS; i++) begin
            @(negedge clk);
            dbg_addr = reg_addr_t'(i);
            #1;
            assert (dbg_data == model_regs[i]) else begin
                errors++;
                $display("[ERROR] %0t x%0d reads %h, expected %h", $time, i, dbg_data,
                         model_regs[i]);
            end
        end
    endtask

    task automatic run_test(input int num, input string name, input int count,
                            input bit use_mul, input bit use_beq, input bit bursty);
        int err0;
        int com0;
        int sq0;
        err0 = errors;
        com0 = commits;
        sq0  = squashed;
        drive_stream(count, use_mul, use_beq, bursty);
        drain_core();
        assert (credits == ROB_DEPTH) else begin
            errors++;
            $display("[ERROR] %0t idle credits %0d, expected %0d", $time, credits, ROB_DEPTH);
        end
        assert ((commits - com0) + (squashed - sq0) == count) else begin
            errors++;
            $display("[ERROR] %0t %0d committed plus %0d squashed, but %0d sent", $time,
                     commits - com0, squashed - sq0, count);
        end
        check_registers();
        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, sent %0d, committed %0d, squashed %0d", num, name,
                 (errors == err0) ? "ok" : "failed", count, commits - com0, squashed - sq0);
    endtask

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WDOG_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        in_valid = 1'b0;
        in_op    = op_add;
        in_rd    = '0;
        in_a     = '0;
        in_b     = '0;
        dbg_addr = '0;
        rst      = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_test(1, "alu only", N_ALU, 1'b0, 1'b0, 1'b0);
        run_test(2, "mul and alu mix", N_MIX, 1'b1, 1'b0, 1'b0);
        run_test(3, "credit bursts", N_BURST, 1'b1, 1'b0, 1'b1);
        run_test(4, "branches", N_BRANCH, 1'b1, 1'b1, 1'b0);

        $display("tests 4, failed %0d, commits %0d, squashed %0d, errors %0d",
                 tests_failed, commits, squashed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
